//--- common/cnn_consts.svh
`ifndef CNN_CONSTS_SVH
`define CNN_CONSTS_SVH

// features per step
`define CNN_LANES 4

// steps per feature vector
`define CNN_STEPS 4

// one neuron per class
`define CNN_CLASSES 10

// data and accumulator width
`define CNN_DW 32

`define CNN_CLS_W 4

// register levels in the argmax tree
`define CNN_TREE_LAT 4

`endif

//--- common/cnn_pkg.sv
`include "cnn_consts.svh"

package cnn_pkg;

    typedef logic signed [`CNN_DW-1:0] data_t;

    typedef struct packed {
        data_t [`CNN_LANES-1:0] lane;
    } feat_vec_t;

    typedef data_t [`CNN_CLASSES-1:0] class_scores_t;

    typedef logic [`CNN_CLS_W-1:0] class_idx_t;
    typedef logic [`CNN_CLASSES-1:0] class_vec_t;

    typedef logic [$clog2(`CNN_STEPS)-1:0] step_idx_t;
    typedef logic [$clog2(`CNN_LANES)-1:0] lane_idx_t;

    // one weight write, sel is one-hot over neurons
    typedef struct packed {
        class_vec_t sel;
        step_idx_t  step;
        lane_idx_t  lane;
        data_t      value;
    } weight_wr_t;

    typedef enum logic [1:0] {
        IDLE,
        FC,
        CLASSES
    } cnn_state_e;

endpackage

//--- fc/fc_neuron.sv
`timescale 1ns/10ps
`include "cnn_consts.svh"

module fc_neuron (
    input  logic                clk,
    input  logic                rstn,
    input  cnn_pkg::weight_wr_t wr,
    input  logic                sel,
    input  logic                acc_clr,
    input  logic                step_valid,
    input  cnn_pkg::feat_vec_t  feat,
    output cnn_pkg::data_t      score,
    output logic                ovalid
);
    import cnn_pkg::*;

    data_t     w_mem [`CNN_STEPS][`CNN_LANES];
    step_idx_t step_cnt;
    data_t     dot;
    data_t     prod_sum;
    logic      prod_valid;
    logic      prod_last;
    data_t     acc;

    always_ff @(posedge clk) begin
        if (sel) begin
            w_mem[wr.step][wr.lane] <= wr.value;
        end
    end

    // lane products of the current step, summed
    always_comb begin
        dot = '0;
        for (int l = 0; l < `CNN_LANES; l++) begin
            dot = dot + feat.lane[l] * w_mem[step_cnt][l];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            step_cnt   <= '0;
            prod_valid <= 1'b0;
            prod_last  <= 1'b0;
            ovalid     <= 1'b0;
        end else if (acc_clr) begin
            step_cnt   <= '0;
            prod_valid <= 1'b0;
            prod_last  <= 1'b0;
            ovalid     <= 1'b0;
        end else begin
            prod_valid <= step_valid;
            prod_last  <= step_valid && (step_cnt == `CNN_STEPS - 1);
            // last sum lands in acc on the same edge
            ovalid     <= prod_last;
            if (step_valid) begin
                step_cnt <= (step_cnt == `CNN_STEPS - 1) ? '0 : step_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step_valid) begin
            prod_sum <= dot;
        end
        if (acc_clr) begin
            acc <= '0;
        end else if (prod_valid) begin
            acc <= acc + prod_sum;
        end
    end

    assign score = acc;

endmodule

//--- fc/fc_layer.sv
`timescale 1ns/10ps
`include "cnn_consts.svh"

module fc_layer (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   load_en,
    input  logic                   weight_valid,
    input  cnn_pkg::data_t         weight,
    input  logic                   acc_clr,
    input  logic                   step_valid,
    input  cnn_pkg::feat_vec_t     feat,
    output cnn_pkg::class_scores_t scores,
    output logic                   all_ovalid
);
    import cnn_pkg::*;

    logic                    take;
    lane_idx_t               lane_cnt;
    step_idx_t               step_cnt;
    class_idx_t              nrn_cnt;
    class_vec_t              wr_sel;
    step_idx_t               wr_step;
    lane_idx_t               wr_lane;
    data_t                   wr_value;
    weight_wr_t              wr;
    logic [`CNN_CLASSES-1:0] ovalid;

    assign take = load_en && weight_valid;

    // neuron-major, then step, then lane; wraps after the last weight
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lane_cnt <= '0;
            step_cnt <= '0;
            nrn_cnt  <= '0;
            wr_sel   <= '0;
        end else begin
            wr_sel <= take ? (class_vec_t'(1) << nrn_cnt) : '0;
            if (take) begin
                if (lane_cnt == `CNN_LANES - 1) begin
                    lane_cnt <= '0;
                    if (step_cnt == `CNN_STEPS - 1) begin
                        step_cnt <= '0;
                        nrn_cnt  <= (nrn_cnt == `CNN_CLASSES - 1) ? '0 : nrn_cnt + 1'b1;
                    end else begin
                        step_cnt <= step_cnt + 1'b1;
                    end
                end else begin
                    lane_cnt <= lane_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            wr_step  <= step_cnt;
            wr_lane  <= lane_cnt;
            wr_value <= weight;
        end
    end

    assign wr = '{sel: wr_sel, step: wr_step, lane: wr_lane, value: wr_value};

    for (genvar i = 0; i < `CNN_CLASSES; i++) begin : g_nrn
        fc_neuron u_nrn (
            .clk        (clk),
            .rstn       (rstn),
            .wr         (wr),
            .sel        (wr.sel[i]),
            .acc_clr    (acc_clr),
            .step_valid (step_valid),
            .feat       (feat),
            .score      (scores[i]),
            .ovalid     (ovalid[i])
        );
    end

    assign all_ovalid = &ovalid;

endmodule

//--- hdl/argmax_tree.sv
`timescale 1ns/10ps
`include "cnn_consts.svh"

module argmax_tree (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   in_valid,
    input  cnn_pkg::class_scores_t scores,
    output logic                   out_valid,
    output cnn_pkg::class_idx_t    win_idx
);
    import cnn_pkg::*;

    typedef struct packed {
        data_t      val;
        class_idx_t idx;
    } cand_t;

    logic [`CNN_TREE_LAT-1:0] vld;

    // left only wins when strictly greater, so ties go to the higher index
    function automatic cand_t max2(input cand_t l, input cand_t r);
        return ($signed(l.val) > $signed(r.val)) ? l : r;
    endfunction

    // candidates remaining after n levels
    function automatic int width_at(input int n);
        return (`CNN_CLASSES + (1 << n) - 1) >> n;
    endfunction

    for (genvar lv = 0; lv <= `CNN_TREE_LAT; lv++) begin : g_lvl
        localparam int N = width_at(lv);
        cand_t node [N];
        if (lv == 0) begin : g_leaf
            for (genvar k = 0; k < N; k++) begin : g_in
                assign node[k] = '{val: scores[k], idx: class_idx_t'(k)};
            end
        end else begin : g_reg
            localparam int N_IN = width_at(lv - 1);
            for (genvar k = 0; k < N; k++) begin : g_node
                if (2 * k + 1 < N_IN) begin : g_cmp
                    always_ff @(posedge clk) begin
                        node[k] <= max2(g_lvl[lv-1].node[2*k], g_lvl[lv-1].node[2*k+1]);
                    end
                end else begin : g_pass
                    // odd one out waits a level
                    always_ff @(posedge clk) begin
                        node[k] <= g_lvl[lv-1].node[2*k];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld <= '0;
        end else begin
            vld <= {vld[`CNN_TREE_LAT-2:0], in_valid};
        end
    end

    assign out_valid = vld[`CNN_TREE_LAT-1];
    assign win_idx   = g_lvl[`CNN_TREE_LAT].node[0].idx;

endmodule

//--- hdl/cnn_ctrl.sv
`timescale 1ns/10ps

module cnn_ctrl (
    input  logic                clk,
    input  logic                rstn,
    input  logic                start,
    input  logic                feat_valid,
    input  logic                all_ovalid,
    input  logic                out_valid,
    input  cnn_pkg::class_idx_t win_idx,
    output logic                load_en,
    output logic                acc_clr,
    output logic                step_valid,
    output logic                tree_valid,
    output cnn_pkg::class_vec_t classes,
    output logic                done
);
    import cnn_pkg::*;

    cnn_state_e state;
    cnn_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (start) state_nxt = FC;
            FC:      if (all_ovalid) state_nxt = CLASSES;
            CLASSES: if (out_valid) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    assign load_en    = (state == IDLE);
    // clear lands on the IDLE to FC edge
    assign acc_clr    = (state == IDLE) && start;
    assign step_valid = (state == FC) && feat_valid;
    // scores are settled once every neuron reports
    assign tree_valid = (state == FC) && all_ovalid;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= IDLE;
            classes <= '0;
            done    <= 1'b0;
        end else begin
            state <= state_nxt;
            done  <= (state == CLASSES) && out_valid;
            // whole vector rewritten, old class bit goes away
            if ((state == CLASSES) && out_valid) begin
                classes <= class_vec_t'(1) << win_idx;
            end
        end
    end

endmodule

//--- hdl/cnn_classifier.sv
`timescale 1ns/10ps

module cnn_classifier (
    input  logic                clk,
    input  logic                rstn,
    input  logic                weight_valid,
    input  cnn_pkg::data_t      weight,
    input  logic                start,
    input  logic                feat_valid,
    input  cnn_pkg::feat_vec_t  feat,
    output cnn_pkg::class_vec_t classes,
    output logic                done
);
    import cnn_pkg::*;

    logic          load_en;
    logic          acc_clr;
    logic          step_valid;
    logic          tree_valid;
    logic          all_ovalid;
    logic          out_valid;
    class_idx_t    win_idx;
    class_scores_t scores;

    cnn_ctrl u_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .start      (start),
        .feat_valid (feat_valid),
        .all_ovalid (all_ovalid),
        .out_valid  (out_valid),
        .win_idx    (win_idx),
        .load_en    (load_en),
        .acc_clr    (acc_clr),
        .step_valid (step_valid),
        .tree_valid (tree_valid),
        .classes    (classes),
        .done       (done)
    );

    // weights stream in only while idle
    fc_layer u_layer (
        .clk          (clk),
        .rstn         (rstn),
        .load_en      (load_en),
        .weight_valid (weight_valid),
        .weight       (weight),
        .acc_clr      (acc_clr),
        .step_valid   (step_valid),
        .feat         (feat),
        .scores       (scores),
        .all_ovalid   (all_ovalid)
    );

    argmax_tree u_tree (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (tree_valid),
        .scores    (scores),
        .out_valid (out_valid),
        .win_idx   (win_idx)
    );

endmodule

//--- testbench/cnn_chk.sv
`timescale 1ns/10ps

module cnn_chk (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   done,
    input  cnn_pkg::class_vec_t    classes,
    input  logic                   load_en,
    input  logic                   acc_clr,
    input  cnn_pkg::class_scores_t scores
);
    int fail_cnt;

    initial begin
        fail_cnt = 0;
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rstn) done |=> !done)
        else begin
            $error("done stayed high for two cycles");
            fail_cnt++;
        end

    a_onehot: assert property (@(posedge clk) disable iff (!rstn) done |-> $onehot(classes))
        else begin
            $error("classes not one-hot while done is high");
            fail_cnt++;
        end

    // accumulators hold still while weights load
    a_no_feat_idle: assert property (@(posedge clk) disable iff (!rstn)
                                     (load_en && !acc_clr) |=> $stable(scores))
        else begin
            $error("feature step accepted during weight load");
            fail_cnt++;
        end

endmodule

bind cnn_classifier cnn_chk u_chk (
    .clk     (clk),
    .rstn    (rstn),
    .done    (done),
    .classes (classes),
    .load_en (load_en),
    .acc_clr (acc_clr),
    .scores  (scores)
);

//--- testbench/tb_cnn.sv
`timescale 1ns/10ps
`include "cnn_consts.svh"

module tb_cnn;
    import cnn_pkg::*;

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 8;
    localparam int N_WEIGHTS    = `CNN_CLASSES * `CNN_STEPS * `CNN_LANES;
    localparam int LATENCY      = `CNN_TREE_LAT + 3;
    localparam int DONE_WAIT    = LATENCY + 8;
    localparam int CASE_CYCLES  = N_WEIGHTS + 3 * `CNN_STEPS + DONE_WAIT + 16;

    logic       clk;
    logic       rstn;
    logic       weight_valid;
    data_t      weight;
    logic       start;
    logic       feat_valid;
    feat_vec_t  feat;
    class_vec_t classes;
    logic       done;

    data_t  w_tab [`CNN_CLASSES][`CNN_STEPS][`CNN_LANES];
    data_t  f_tab [`CNN_STEPS][`CNN_LANES];
    int     seed;
    int     fd;
    int     err_cnt;
    int     run_cnt;
    longint watch_ns = 0;

    cnn_classifier dut0 (
        .clk          (clk),
        .rstn         (rstn),
        .weight_valid (weight_valid),
        .weight       (weight),
        .start        (start),
        .feat_valid   (feat_valid),
        .feat         (feat),
        .classes      (classes),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        wait (watch_ns > 0);
        #(watch_ns);
        $display("watchdog expired after %0d ns, the run did not finish", watch_ns);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_classes(input class_vec_t got, input class_vec_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_idx(input class_idx_t got, input class_idx_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("CHECK FAILED at %0t: %s got %0d cycles expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic read_value(output int v);
        if ($fscanf(fd, "%d", v) != 1) begin
            $display("trace file is malformed after run %0d", run_cnt);
            err_cnt++;
            v = 0;
        end
    endtask

    // dot products from the loaded weights, highest index wins a tie
    function automatic class_idx_t model_class();
        data_t      score;
        data_t      best;
        class_idx_t idx;
        best = '0;
        idx  = '0;
        for (int n = 0; n < `CNN_CLASSES; n++) begin
            score = '0;
            for (int s = 0; s < `CNN_STEPS; s++) begin
                for (int l = 0; l < `CNN_LANES; l++) begin
                    score = score + f_tab[s][l] * w_tab[n][s][l];
                end
            end
            if (n == 0 || score >= best) begin
                best = score;
                idx  = class_idx_t'(n);
            end
        end
        return idx;
    endfunction

    task automatic load_weights();
        for (int n = 0; n < `CNN_CLASSES; n++) begin
            for (int s = 0; s < `CNN_STEPS; s++) begin
                for (int l = 0; l < `CNN_LANES; l++) begin
                    @(negedge clk);
                    weight_valid = 1'b1;
                    weight       = w_tab[n][s][l];
                end
            end
        end
        @(negedge clk);
        weight_valid = 1'b0;
        weight       = '0;
        repeat (2) @(negedge clk);
    endtask

    task automatic run_case();
        int         pre;
        int         exp_v;
        int         gap;
        int         cyc;
        int         v;
        class_idx_t exp_idx;
        class_idx_t got_idx;
        read_value(pre);
        for (int s = 0; s < `CNN_STEPS; s++) begin
            for (int l = 0; l < `CNN_LANES; l++) begin
                read_value(v);
                f_tab[s][l] = data_t'(v);
            end
        end
        read_value(exp_v);
        exp_idx = class_idx_t'(exp_v);
        run_cnt++;
        check_idx(model_class(), exp_idx, $sformatf("run %0d trace class vs model", run_cnt));
        // junk strobes while idle
        repeat (pre) begin
            @(negedge clk);
            feat_valid = 1'b1;
            for (int l = 0; l < `CNN_LANES; l++) begin
                feat.lane[l] = $random(seed);
            end
        end
        @(negedge clk);
        feat_valid = 1'b0;
        start      = 1'b1;
        @(negedge clk);
        start = 1'b0;
        for (int s = 0; s < `CNN_STEPS; s++) begin
            gap = {$random(seed)} % 3;
            repeat (gap) @(negedge clk);
            for (int l = 0; l < `CNN_LANES; l++) begin
                feat.lane[l] = f_tab[s][l];
            end
            feat_valid = 1'b1;
            @(negedge clk);
            feat_valid = 1'b0;
        end
        cyc = 1;
        while (!done && cyc < DONE_WAIT) begin
            @(negedge clk);
            cyc++;
        end
        if (!done) begin
            $display("run %0d: no done pulse within %0d cycles of the last feature step",
                     run_cnt, DONE_WAIT);
            err_cnt++;
        end else begin
            got_idx = '0;
            for (int i = 0; i < `CNN_CLASSES; i++) begin
                if (classes[i]) begin
                    got_idx = class_idx_t'(i);
                end
            end
            check_latency(cyc, LATENCY, $sformatf("run %0d done latency", run_cnt));
            check_classes(classes, class_vec_t'(1) << exp_idx,
                          $sformatf("run %0d classes", run_cnt));
            check_idx(got_idx, exp_idx, $sformatf("run %0d winning index", run_cnt));
        end
        @(negedge clk);
    endtask

    initial begin
        logic [63:0]   tag;
        logic [2047:0] line_buf;
        int            n_lines;
        int            n;
        int            v;
        bit            dirty;
        rstn         = 1'b0;
        weight_valid = 1'b0;
        weight       = '0;
        start        = 1'b0;
        feat_valid   = 1'b0;
        feat         = '0;
        seed         = 33;
        err_cnt      = 0;
        run_cnt      = 0;
        n_lines      = 0;
        dirty        = 1'b0;

        fd = $fopen("testbench/cnn_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/cnn_trace.txt");
            err_cnt++;
        end else begin
            while ($fgets(line_buf, fd) != 0) begin
                n_lines++;
            end
            $fclose(fd);
            fd = $fopen("testbench/cnn_trace.txt", "r");
        end
        watch_ns = (longint'(n_lines) * CASE_CYCLES + RESET_CYCLES + 4) * PERIOD;

        repeat (RESET_CYCLES) @(negedge clk);
        rstn = 1'b1;
        check_classes(classes, '0, "classes after reset");
        check_flag(done, 1'b0, "done after reset");

        if (fd != 0) begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "#") begin
                    void'($fgets(line_buf, fd));
                end else if (tag == "W" || tag == "L") begin
                    read_value(n);
                    if (n < 0 || n >= `CNN_CLASSES) begin
                        $display("trace names neuron %0d, which does not exist", n);
                        err_cnt++;
                        n = 0;
                    end
                    for (int s = 0; s < `CNN_STEPS; s++) begin
                        for (int l = 0; l < `CNN_LANES; l++) begin
                            read_value(v);
                            w_tab[n][s][l] = data_t'(v);
                        end
                    end
                    dirty = 1'b1;
                end else if (tag == "R") begin
                    // a full stream, the DUT's weight counter wraps
                    if (dirty) begin
                        load_weights();
                        dirty = 1'b0;
                    end
                    run_case();
                end else begin
                    $display("trace holds an unknown line tag");
                    err_cnt++;
                    void'($fgets(line_buf, fd));
                end
            end
            $fclose(fd);
        end

        $display("runs %0d, check errors %0d, assertion errors %0d",
                 run_cnt, err_cnt, dut0.u_chk.fail_cnt);
        if (err_cnt == 0 && dut0.u_chk.fail_cnt == 0 && run_cnt > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+common
common/cnn_pkg.sv
fc/fc_neuron.sv
fc/fc_layer.sv
hdl/argmax_tree.sv
hdl/cnn_ctrl.sv
hdl/cnn_classifier.sv
testbench/cnn_chk.sv
testbench/tb_cnn.sv

//--- run.sh
#!/bin/sh
# build the classifier testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_cnn -o tb_cnn
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cnn +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- testbench/cnn_trace.txt
# W n w[16] = weights of neuron n, step-major | L n w[16] = reload neuron n, then stream all weights
# R pre f[16] class = run with pre idle strobes first, features step-major, expected class index
W 0 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 -4
W 1 0 2 0 0 0 0 0 0 0 0 0 0 0 0 0 -3
W 2 0 0 2 0 0 0 0 0 0 0 0 0 0 0 0 -2
W 3 0 0 0 2 0 0 0 0 0 0 0 0 0 0 0 -1
W 4 0 0 0 0 2 0 0 0 0 0 0 0 0 0 0 0
W 5 0 0 0 0 0 2 0 0 0 0 0 0 0 0 0 1
W 6 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 2
W 7 0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 3
W 8 0 0 0 0 0 0 0 0 2 0 0 0 0 0 0 4
W 9 0 0 0 0 0 0 0 0 0 2 0 0 0 0 0 5
R 0 3 1 4 1 5 9 2 6 5 3 0 0 0 0 0 2 5
R 2 1 7 2 7 0 3 7 1 0 4 0 0 0 0 0 0 6
R 1 -5 -3 -8 -2 -9 -4 -7 -6 -3 -10 0 0 9 0 0 0 3
L 0 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
L 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 20
R 0 3 1 4 1 5 9 2 6 5 3 0 0 0 0 0 2 2
R 3 1 7 2 7 0 3 7 1 0 4 0 0 0 0 0 0 6
R 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 -1 1
L 0 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 -4
L 2 0 0 2 0 0 0 0 0 0 0 0 0 0 0 0 -2
R 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 9
R 1 3 1 4 1 5 9 2 6 5 3 0 0 0 0 0 2 5
R 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 -5 0
